// File: ncpu32k_config.svh
`ifndef NCPU32K_CONFIG_SVH
`define NCPU32K_CONFIG_SVH

// Byte address and instruction widths
`define NCPU_AW 32
`define NCPU_IW 32

// First fetch byte address out of reset
`define NCPU_ERST_VECTOR 32'h0000_0000

// Predictor has 2**N entries, counters start weakly not taken
`define NCPU_BPU_DEPTH_LOG2 4
`define NCPU_BPU_CNT_INIT 2'b01

// Opcodes in insn[5:0]
`define NCPU_OP_JMPREL 6'd1
`define NCPU_OP_BT 6'd2
`define NCPU_OP_BF 6'd3
`define NCPU_OP_JMPFAR 6'd4

// Predictor config port
`define NCPU_CSR_AW 1
`define NCPU_CSR_DW 16
`define NCPU_CSR_ADDR_EN 1'b0
`define NCPU_CSR_ADDR_CNT 1'b1

`endif

// File: ncpu32k_pkg.sv
`include "ncpu32k_config.svh"

package ncpu32k_pkg;

   // Word address, low two byte bits dropped
   typedef logic [`NCPU_AW-3:0] pc_t;
   typedef logic [`NCPU_IW-1:0] insn_t;

   // Predecoder result
   typedef struct packed {
      logic op_jmprel;
      logic op_bcc;
      logic op_bt;
      logic op_jmpfar;
      logic link;
      // Sign-extended word offset
      pc_t  offset;
   } pdec_t;

   // Predictor lookup
   typedef struct packed {
      logic rd;
      pc_t  pc;
   } bpu_req_t;

   typedef struct packed {
      logic taken;
      pc_t  tgt;
   } bpu_rsp_t;

   // Training from execute
   typedef struct packed {
      logic valid;
      pc_t  pc;
      logic is_far;
      logic taken;
      pc_t  tgt;
   } bpu_train_t;

   // Packet handed to decode
   typedef struct packed {
      insn_t insn;
      pc_t   pc;
      logic  op_jmprel;
      logic  op_jmpfar;
      logic  jmprel_link;
      logic  specul_jmprel;
      logic  specul_jmpfar;
      logic  specul_bcc;
      // Target to take if the prediction was wrong
      pc_t   specul_tgt;
   } fetch_pkt_t;

endpackage

// File: ncpu32k_ipdu.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module ncpu32k_ipdu (
   input  ncpu32k_pkg::insn_t insn,
   output ncpu32k_pkg::pdec_t pdec
);

   logic [5:0] opcode;

   // Opcode field
   assign opcode = insn[5:0];

   always_comb begin
      pdec.op_jmprel = (opcode == `NCPU_OP_JMPREL);
      pdec.op_bt     = (opcode == `NCPU_OP_BT);
      // BT or BF
      pdec.op_bcc    = (opcode == `NCPU_OP_BT) | (opcode == `NCPU_OP_BF);
      pdec.op_jmpfar = (opcode == `NCPU_OP_JMPFAR);
      // Link only meaningful on JMPREL
      pdec.link      = (opcode == `NCPU_OP_JMPREL) & insn[6];
      // Offset in insn[31:7], sign-extended to word address width
      // Extracted for every opcode, consumers qualify it
      pdec.offset    = {{(`NCPU_AW-`NCPU_IW+5){insn[`NCPU_IW-1]}}, insn[`NCPU_IW-1:7]};
   end

endmodule

// File: ncpu32k_bpu.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module ncpu32k_bpu (
   input  logic                    clk,
   input  logic                    rst_n,
   input  ncpu32k_pkg::bpu_req_t   req,
   output ncpu32k_pkg::bpu_rsp_t   rsp,
   input  logic                    is_bcc,
   input  ncpu32k_pkg::bpu_train_t train,
   input  logic                    en,
   output logic                    pred_taken
);
   import ncpu32k_pkg::*;

   localparam int DEPTH = 1 << `NCPU_BPU_DEPTH_LOG2;

   // Two-bit direction counters and far targets
   logic [1:0] cnt_tab [DEPTH];
   pc_t        tgt_tab [DEPTH];

   logic [`NCPU_BPU_DEPTH_LOG2-1:0] rd_idx;
   logic [`NCPU_BPU_DEPTH_LOG2-1:0] wr_idx;
   logic                            dir_taken;

   // Direct mapped on low pc bits
   assign rd_idx = req.pc[`NCPU_BPU_DEPTH_LOG2-1:0];
   assign wr_idx = train.pc[`NCPU_BPU_DEPTH_LOG2-1:0];

   // Counter MSB, forced not taken when disabled
   assign dir_taken = cnt_tab[rd_idx][1] & en;

   always_comb begin
      rsp.tgt = tgt_tab[rd_idx];
      // Far jumps always taken
      rsp.taken = req.rd & (is_bcc ? dir_taken : 1'b1);
   end

   // One pulse per conditional lookup predicted taken
   assign pred_taken = req.rd & is_bcc & dir_taken;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            cnt_tab[i] <= `NCPU_BPU_CNT_INIT;
            tgt_tab[i] <= '0;
         end
      end else if (train.valid) begin
         if (train.is_far) begin
            tgt_tab[wr_idx] <= train.tgt;
         end else if (train.taken) begin
            // Saturate at strongly taken
            if (cnt_tab[wr_idx] != 2'b11) begin
               cnt_tab[wr_idx] <= cnt_tab[wr_idx] + 1'b1;
            end
         end else begin
            // Saturate at strongly not taken
            if (cnt_tab[wr_idx] != 2'b00) begin
               cnt_tab[wr_idx] <= cnt_tab[wr_idx] - 1'b1;
            end
         end
      end
   end

endmodule

// File: ncpu32k_bpu_csr.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module ncpu32k_bpu_csr (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    csr_req,
   input  logic                    csr_we,
   input  logic [`NCPU_CSR_AW-1:0] csr_addr,
   input  logic [`NCPU_CSR_DW-1:0] csr_wdata,
   output logic                    csr_ack,
   output logic [`NCPU_CSR_DW-1:0] csr_rdata,
   output logic                    en,
   input  logic                    pred_taken
);

   logic [`NCPU_CSR_DW-1:0] taken_cnt;
   logic                    req_rise;

   // Request seen but not yet acknowledged
   assign req_rise = csr_req & ~csr_ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_ack   <= 1'b0;
         en        <= 1'b1;
         taken_cnt <= '0;
      end else begin
         // Ack trails req by one cycle in both directions
         csr_ack <= csr_req;
         // Write lands on the ack rising edge
         if (req_rise & csr_we & (csr_addr == `NCPU_CSR_ADDR_EN)) begin
            en <= csr_wdata[0];
         end
         // Saturating count of taken predictions
         if (pred_taken && (taken_cnt != '1)) begin
            taken_cnt <= taken_cnt + 1'b1;
         end
      end
   end

   // Read data held while ack is high
   assign csr_rdata = (csr_addr == `NCPU_CSR_ADDR_CNT) ? taken_cnt
                                                        : {{(`NCPU_CSR_DW-1){1'b0}}, en};

endmodule

// File: ncpu32k_pipebuf.sv
`timescale 1ns/1ns

module ncpu32k_pipebuf #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   logic full;
   logic load;

   // Accept when empty or when the held entry leaves this cycle
   assign in_ready  = ~full | out_ready;
   assign load      = in_valid & in_ready;
   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (load) begin
         full <= 1'b1;
      end else if (out_ready) begin
         full <= 1'b0;
      end
   end

   // Cleared so decode never sees stale flags out of reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_data <= '0;
      end else if (load) begin
         out_data <= in_data;
      end
   end

endmodule

// File: ncpu32k_ifu.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module ncpu32k_ifu (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    ibus_valid,
   input  ncpu32k_pkg::insn_t      ibus_insn,
   input  logic [`NCPU_AW-1:0]     ibus_id,
   output logic                    ibus_ready,
   output logic [`NCPU_AW-1:0]     ibus_addr,
   input  logic                    flush,
   input  ncpu32k_pkg::pc_t        flush_tgt,
   input  ncpu32k_pkg::pdec_t      pdec,
   output ncpu32k_pkg::insn_t      ipdu_insn,
   output ncpu32k_pkg::bpu_req_t   bpu_req,
   output logic                    bpu_is_bcc,
   input  ncpu32k_pkg::bpu_rsp_t   bpu_rsp,
   output logic                    pkt_valid,
   output ncpu32k_pkg::fetch_pkt_t pkt,
   input  logic                    pkt_ready
);
   import ncpu32k_pkg::*;

   logic [1:0] start_cnt;
   logic       started;
   logic       booted;
   logic       fire;
   logic       rel_taken;
   logic       keep;
   pc_t        beat_pc;
   pc_t        seq_tgt;
   pc_t        rel_tgt;
   pc_t        nxt_pc;

   // Startup delay, ready held low for two cycles after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         start_cnt <= '0;
      end else if (!start_cnt[1]) begin
         start_cnt <= start_cnt + 1'b1;
      end
   end

   assign started = start_cnt[1];

   // First beat only hands the reset vector to memory
   // Its data is not forwarded to decode
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         booted <= 1'b0;
      end else if (fire) begin
         booted <= 1'b1;
      end
   end

   // Stall on a full buffer that decode is not draining
   assign ibus_ready = started & (pkt_ready | ~booted);
   assign fire       = ibus_valid & ibus_ready;

   assign ipdu_insn = ibus_insn;
   assign beat_pc   = ibus_id[`NCPU_AW-1:2];
   assign seq_tgt   = beat_pc + 1'b1;
   assign rel_tgt   = beat_pc + pdec.offset;

   // Lookup only on real accepted beats, so the taken count is exact
   assign bpu_req.rd = fire & booted & ~flush & (pdec.op_bcc | pdec.op_jmpfar);
   assign bpu_req.pc = beat_pc;
   assign bpu_is_bcc = pdec.op_bcc;

   // JMPREL always, BT/BF when predicted
   assign rel_taken = pdec.op_jmprel | (pdec.op_bcc & bpu_rsp.taken);

   // Next fetch address, flush first
   always_comb begin
      if (flush) begin
         nxt_pc = flush_tgt;
      end else if (pdec.op_jmpfar) begin
         nxt_pc = bpu_rsp.tgt;
      end else if (rel_taken) begin
         nxt_pc = rel_tgt;
      end else begin
         nxt_pc = seq_tgt;
      end
   end

   assign ibus_addr = booted ? {nxt_pc, 2'b00} : `NCPU_ERST_VECTOR;

   // Valid never waits on ready
   assign pkt_valid = ibus_valid & started & booted;

   // Flushed beat still travels, as a bubble
   assign keep = ~flush;

   always_comb begin
      pkt.pc            = beat_pc;
      // Contrary target, used by execute on mispredict
      pkt.specul_tgt    = bpu_rsp.taken ? seq_tgt : rel_tgt;
      pkt.insn          = keep ? ibus_insn : '0;
      pkt.op_jmprel     = pdec.op_jmprel & keep;
      pkt.op_jmpfar     = pdec.op_jmpfar & keep;
      pkt.jmprel_link   = pdec.link & keep;
      pkt.specul_jmprel = pdec.op_bcc & keep;
      pkt.specul_jmpfar = pdec.op_jmpfar & keep;
      // Predicted condition flag, BT taken only
      pkt.specul_bcc    = pdec.op_bt & bpu_rsp.taken & keep;
   end

endmodule

// File: ncpu32k_fetch_top.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module ncpu32k_fetch_top (
   input  logic                    clk,
   input  logic                    rst_n,
   // Instruction bus
   input  logic                    ibus_valid,
   input  ncpu32k_pkg::insn_t      ibus_insn,
   input  logic [`NCPU_AW-1:0]     ibus_id,
   output logic                    ibus_ready,
   output logic [`NCPU_AW-1:0]     ibus_addr,
   // Toward decode
   output logic                    idu_valid,
   output ncpu32k_pkg::fetch_pkt_t idu_pkt,
   input  logic                    idu_ready,
   // From execute
   input  logic                    flush,
   input  ncpu32k_pkg::pc_t        flush_tgt,
   input  ncpu32k_pkg::bpu_train_t train,
   // Predictor config, four-phase
   input  logic                    csr_req,
   input  logic                    csr_we,
   input  logic [`NCPU_CSR_AW-1:0] csr_addr,
   input  logic [`NCPU_CSR_DW-1:0] csr_wdata,
   output logic                    csr_ack,
   output logic [`NCPU_CSR_DW-1:0] csr_rdata
);
   import ncpu32k_pkg::*;

   insn_t      ipdu_insn;
   pdec_t      pdec;
   bpu_req_t   bpu_req;
   bpu_rsp_t   bpu_rsp;
   logic       bpu_is_bcc;
   logic       bpu_en;
   logic       pred_taken;
   logic       pkt_valid;
   logic       pkt_ready;
   fetch_pkt_t pkt;

   ncpu32k_ifu i_ifu (
      .clk        (clk),
      .rst_n      (rst_n),
      .ibus_valid (ibus_valid),
      .ibus_insn  (ibus_insn),
      .ibus_id    (ibus_id),
      .ibus_ready (ibus_ready),
      .ibus_addr  (ibus_addr),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .pdec       (pdec),
      .ipdu_insn  (ipdu_insn),
      .bpu_req    (bpu_req),
      .bpu_is_bcc (bpu_is_bcc),
      .bpu_rsp    (bpu_rsp),
      .pkt_valid  (pkt_valid),
      .pkt        (pkt),
      .pkt_ready  (pkt_ready)
   );

   ncpu32k_ipdu i_ipdu (
      .insn (ipdu_insn),
      .pdec (pdec)
   );

   ncpu32k_bpu i_bpu (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (bpu_req),
      .rsp        (bpu_rsp),
      .is_bcc     (bpu_is_bcc),
      .train      (train),
      .en         (bpu_en),
      .pred_taken (pred_taken)
   );

   // Enable and taken count for the predictor
   ncpu32k_bpu_csr i_bpu_csr (
      .clk        (clk),
      .rst_n      (rst_n),
      .csr_req    (csr_req),
      .csr_we     (csr_we),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .csr_ack    (csr_ack),
      .csr_rdata  (csr_rdata),
      .en         (bpu_en),
      .pred_taken (pred_taken)
   );

   // One-entry slice toward decode
   ncpu32k_pipebuf #(
      .payload_t (fetch_pkt_t)
   ) i_pipebuf (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (pkt_valid),
      .in_data   (pkt),
      .in_ready  (pkt_ready),
      .out_valid (idu_valid),
      .out_data  (idu_pkt),
      .out_ready (idu_ready)
   );

endmodule

// File: ncpu32k_fetch_assertions.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module ncpu32k_fetch_assertions (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    ibus_ready,
   input logic                    idu_valid,
   input logic                    idu_ready,
   input ncpu32k_pkg::fetch_pkt_t idu_pkt,
   input logic                    csr_req,
   input logic                    csr_ack
);

   // Stalled packet must stay put until decode takes it
   held_pkt_stable: assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid && !idu_ready |=> idu_valid && $stable(idu_pkt))
      else $error("packet changed under back-pressure");

   // Ack is req delayed by one cycle
   ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
      1'b1 |=> csr_ack == $past(csr_req))
      else $error("csr_ack did not follow csr_req");

   // Nothing leaves the unit while in reset
   quiet_in_reset: assert property (@(posedge clk)
      !rst_n |=> !ibus_ready && !idu_valid)
      else $error("handshake active during reset");

endmodule

bind ncpu32k_fetch_top ncpu32k_fetch_assertions i_fetch_assertions (.*);

// File: tb_fetch_top.sv
`timescale 1ns/1ns
`include "ncpu32k_config.svh"

module tb_fetch_top;
   import ncpu32k_pkg::*;

   logic clk;
   logic rst_n;
   logic ibus_valid;
   insn_t ibus_insn;
   logic [`NCPU_AW-1:0] ibus_id;
   logic ibus_ready;
   logic [`NCPU_AW-1:0] ibus_addr;
   logic idu_valid;
   fetch_pkt_t idu_pkt;
   logic idu_ready;
   logic flush;
   pc_t flush_tgt;
   bpu_train_t train;
   logic csr_req;
   logic csr_we;
   logic [`NCPU_CSR_AW-1:0] csr_addr;
   logic [`NCPU_CSR_DW-1:0] csr_wdata;
   logic csr_ack;
   logic [`NCPU_CSR_DW-1:0] csr_rdata;

   insn_t mem [256];
   int errors;
   int n_out;
   int wait_cnt;
   logic exec_on;
   // Reference model state
   logic [1:0] m_cnt [16];
   pc_t m_tgt [16];
   logic m_en;
   logic [15:0] m_count;
   logic m_booted;
   // Packets still owed to decode, oldest first
   fetch_pkt_t exp_q [$];

   ncpu32k_fetch_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Runtime bound from 3000 transactions of 20 cycles each
   initial begin
      #(3000 * 20 * 20);
      $display("Timeout: the run did not reach its last transaction");
      $display("Some tests failed");
      $finish;
   end

   task automatic check_pc(input string name, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED t=%0t idu_pkt got %h exp %h", $time, got, exp);
      end
   endtask

   task automatic check_word(input string name, input logic [`NCPU_CSR_DW-1:0] got,
                             input logic [`NCPU_CSR_DW-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   // Weighted opcode mix with only ordinary words below address 32
   task automatic fill_mem();
      int r;
      int off;
      logic [5:0] op;
      for (int a = 0; a < 256; a++) begin
         r = int'($urandom % 10);
         off = int'($urandom % 32) - 16;
         if (r < 6 || a < 32) begin
            op = ($urandom % 2 == 0) ? 6'd0 : 6'(5 + $urandom % 59);
         end else begin
            op = 6'(r - 5);
         end
         mem[a] = {off[24:0], 1'($urandom % 2), op};
      end
   endtask

   // One four-phase transfer on the config port
   task automatic csr_xfer(input logic we, input logic [`NCPU_CSR_AW-1:0] a,
                           input logic [`NCPU_CSR_DW-1:0] d);
      @(posedge clk);
      csr_req <= 1'b1;
      csr_we <= we;
      csr_addr <= a;
      csr_wdata <= d;
      do @(posedge clk); while (!csr_ack);
      csr_req <= 1'b0;
      do @(posedge clk); while (csr_ack);
   endtask

   task automatic wait_out(input int n);
      while (n_out < n) @(posedge clk);
   endtask

   // Memory presents the captured address after 0 to 2 cycles
   always @(posedge clk) begin
      if (!rst_n) begin
         ibus_valid <= 1'b1;
         ibus_id <= `NCPU_ERST_VECTOR;
         ibus_insn <= mem[0];
         wait_cnt = 0;
      end else if (ibus_valid && ibus_ready) begin
         ibus_id <= ibus_addr;
         ibus_insn <= mem[ibus_addr[9:2]];
         wait_cnt = int'($urandom % 3);
         ibus_valid <= (wait_cnt == 0);
      end else if (!ibus_valid) begin
         if (wait_cnt <= 1) ibus_valid <= 1'b1;
         wait_cnt--;
      end
   end

   // Decode sink and execute driver
   always @(posedge clk) begin : drivers
      bpu_train_t t;
      idu_ready <= ($urandom % 10) < 7;
      t.valid = exec_on && ($urandom % 4 == 0);
      t.pc = pc_t'($urandom % 16);
      t.is_far = ($urandom % 2 == 0);
      t.taken = ($urandom % 3 != 0);
      t.tgt = pc_t'($urandom % 256);
      train <= t;
      flush <= exec_on && ($urandom % 20 == 0);
      flush_tgt <= pc_t'($urandom % 256);
   end

   // Reference model and checks
   always @(posedge clk) begin : monitor
      fetch_pkt_t e;
      pc_t p;
      pc_t off;
      pc_t nxt;
      logic [5:0] op;
      logic bcc;
      logic far;
      logic taken;
      if (!rst_n) begin
         for (int i = 0; i < 16; i++) begin
            m_cnt[i] = 2'b01;
            m_tgt[i] = '0;
         end
         m_en = 1'b1;
         m_count = '0;
         m_booted = 1'b0;
         exp_q.delete();
      end else begin
         if (csr_req && csr_ack && !csr_we) begin
            if (csr_addr == `NCPU_CSR_ADDR_CNT) check_word("csr_rdata", csr_rdata, m_count);
            else check_word("csr_rdata", csr_rdata, {15'd0, m_en});
         end
         if (idu_valid && idu_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("Decode got a packet that no accepted beat explains at t=%0t", $time);
            end else begin
               check_pkt(idu_pkt, exp_q.pop_front());
            end
            n_out <= n_out + 1;
         end
         // First beat only names the reset vector
         if (ibus_valid && ibus_ready && !m_booted) begin
            check_pc("ibus_addr", ibus_addr[`NCPU_AW-1:2], pc_t'(`NCPU_ERST_VECTOR >> 2));
            m_booted = 1'b1;
         end else if (ibus_valid && ibus_ready) begin
            op = ibus_insn[5:0];
            p = ibus_id[`NCPU_AW-1:2];
            off = {{5{ibus_insn[31]}}, ibus_insn[31:7]};
            bcc = (op == 6'd2) || (op == 6'd3);
            far = (op == 6'd4);
            // No prediction on a flushed beat
            taken = !flush && (far || (bcc && m_cnt[p[3:0]][1] && m_en));
            if (flush) nxt = flush_tgt;
            else if (far) nxt = m_tgt[p[3:0]];
            else if (op == 6'd1 || (bcc && taken)) nxt = p + off;
            else nxt = p + 1'b1;
            check_pc("ibus_addr", ibus_addr[`NCPU_AW-1:2], nxt);
            if (bcc && taken && m_count != 16'hffff) m_count++;
            e = '0;
            e.pc = p;
            e.specul_tgt = taken ? p + 1'b1 : p + off;
            if (!flush) begin
               e.insn = ibus_insn;
               e.op_jmprel = (op == 6'd1);
               e.jmprel_link = (op == 6'd1) && ibus_insn[6];
               e.op_jmpfar = far;
               e.specul_jmpfar = far;
               e.specul_jmprel = bcc;
               e.specul_bcc = (op == 6'd2) && taken;
            end
            exp_q.push_back(e);
         end
         // Writes land when ack rises
         if (csr_req && !csr_ack && csr_we && csr_addr == `NCPU_CSR_ADDR_EN) m_en = csr_wdata[0];
         // Training after the lookup of the same edge
         if (train.valid && train.is_far) begin
            m_tgt[train.pc[3:0]] = train.tgt;
         end else if (train.valid && train.taken && m_cnt[train.pc[3:0]] != 2'b11) begin
            m_cnt[train.pc[3:0]]++;
         end else if (train.valid && !train.taken && m_cnt[train.pc[3:0]] != 2'b00) begin
            m_cnt[train.pc[3:0]]--;
         end
      end
   end

   initial begin
      void'($urandom(32'h9880));
      errors = 0;
      n_out = 0;
      exec_on = 1'b0;
      rst_n = 1'b0;
      ibus_valid = 1'b0;
      ibus_insn = '0;
      ibus_id = '0;
      idu_ready = 1'b0;
      flush = 1'b0;
      flush_tgt = '0;
      train = '0;
      csr_req = 1'b0;
      csr_we = 1'b0;
      csr_addr = '0;
      csr_wdata = '0;
      fill_mem();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      // Straight-line start before jumps, flushes and training
      wait_out(25);
      exec_on <= 1'b1;
      wait_out(1200);
      // Prediction off for the middle stretch
      csr_xfer(1'b1, `NCPU_CSR_ADDR_EN, 16'd0);
      wait_out(1900);
      csr_xfer(1'b0, `NCPU_CSR_ADDR_CNT, 16'd0);
      csr_xfer(1'b0, `NCPU_CSR_ADDR_EN, 16'd0);
      csr_xfer(1'b1, `NCPU_CSR_ADDR_EN, 16'd1);
      wait_out(3000);
      csr_xfer(1'b0, `NCPU_CSR_ADDR_CNT, 16'd0);
      $display("packets %0d errors %0d", n_out, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+.
ncpu32k_pkg.sv
ncpu32k_ipdu.sv
ncpu32k_bpu.sv
ncpu32k_bpu_csr.sv
ncpu32k_pipebuf.sv
ncpu32k_ifu.sv
ncpu32k_fetch_top.sv
ncpu32k_fetch_assertions.sv
tb_fetch_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fetch_top -f vlog.f -o tb_fetch_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi
out=$(./obj_dir/tb_fetch_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if echo "$out" | grep -qx "All tests passed"; then
   exit 0
fi
exit 1
